/* verilog/ttlBusPkg.sv */
`default_nettype none

package ttlBusPkg;

  // External TTL memory bus
  localparam int AddrWidth = 16;
  localparam int DataWidth = 8;

  // BusControlReadReg bits
  localparam int CtrlWidth = 3;
  localparam int CtrlSelBit = 0;
  localparam int CtrlReadBit = 1;
  localparam int CtrlWriteBit = 2;

  // StatusReg bits
  localparam int StatEnableBit = 0;
  localparam int StatErrorBit = 1;
  localparam int StatBusyBit = 2;

  // Bus cycle sequencer states
  localparam int SeqStateWidth = 3;
  localparam logic [SeqStateWidth-1:0] SeqIdle = 3'd0;
  localparam logic [SeqStateWidth-1:0] SeqAddrIntr = 3'd1;
  localparam logic [SeqStateWidth-1:0] SeqWaitStrobe = 3'd2;
  localparam logic [SeqStateWidth-1:0] SeqMstRead = 3'd3;
  localparam logic [SeqStateWidth-1:0] SeqReadIntr = 3'd4;
  localparam logic [SeqStateWidth-1:0] SeqWriteIntr = 3'd5;
  localparam logic [SeqStateWidth-1:0] SeqMstWrite = 3'd6;
  localparam logic [SeqStateWidth-1:0] SeqHold = 3'd7;

endpackage

`default_nettype wire

/* verilog/mstBusPkg.sv */
`default_nettype none

package mstBusPkg;

  // Memory-mapped master port
  localparam int MstAddrWidth = 32;
  localparam int MstDataWidth = 32;

  // Byte lanes of one master word
  localparam int BeWidth = 4;
  localparam int LaneBits = 2;
  localparam int ByteWidth = MstDataWidth / BeWidth;

  // One master word, either whole or split into its byte lanes
  // Lane 0 is the least significant byte
  typedef union packed {
    logic [MstDataWidth-1:0] word;
    logic [BeWidth-1:0][ByteWidth-1:0] bytes;
  } mstWord_t;

endpackage

`default_nettype wire

/* verilog/bridgeIfs.sv */
`timescale 1ns/100ps
`default_nettype none

// Synchronized TTL cycle seen by the sequencer
interface ttlCycleIf;
  import ttlBusPkg::*;

  logic selected;
  logic cycleStart;
  logic readStrobe;
  logic writeStrobe;
  logic [AddrWidth-1:0] address;
  logic [DataWidth-1:0] writeData;
  logic [DataWidth-1:0] readData;
  logic readValid;

  modport front(output selected, cycleStart, readStrobe, writeStrobe, address, writeData,
                input readData, readValid);
  modport seq(input selected, cycleStart, readStrobe, writeStrobe, address, writeData,
              output readData, readValid);
endinterface

// Single byte command to the master port
interface mstCmdIf;
  import mstBusPkg::*;

  logic rdReq;
  logic wrReq;
  logic [MstAddrWidth-1:0] addr;
  logic [ByteWidth-1:0] wrByte;
  logic [ByteWidth-1:0] rdByte;
  logic done;
  logic error;

  modport seq(output rdReq, wrReq, addr, wrByte, input rdByte, done, error);
  modport port(input rdReq, wrReq, addr, wrByte, output rdByte, done, error);
endinterface

`default_nettype wire

/* verilog/ttlBusFrontEnd.sv */
`timescale 1ns/100ps
`default_nettype none

module ttlBusFrontEnd (
  input logic clk,
  input logic rst_n,
  input logic nChipEnable,
  input logic nOutputEnable,
  input logic nWriteEnable,
  input logic [ttlBusPkg::AddrWidth-1:0] Address,
  inout wire [ttlBusPkg::DataWidth-1:0] Data,
  ttlCycleIf.front bus
);
  import ttlBusPkg::*;

  // Strobes are kept active high after the two sync flops
  logic [1:0] selPipe;
  logic [1:0] rdPipe;
  logic [1:0] wrPipe;
  logic selPrev;

  logic [AddrWidth-1:0] addrPipe1;
  logic [AddrWidth-1:0] addrPipe2;
  logic [AddrWidth-1:0] addrPrev;
  logic [DataWidth-1:0] dataPipe1;
  logic [DataWidth-1:0] dataPipe2;

  logic driveData;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      selPipe <= 2'b00;
      rdPipe <= 2'b00;
      wrPipe <= 2'b00;
      selPrev <= 1'b0;
      bus.cycleStart <= 1'b0;
    end else begin
      selPipe <= {selPipe[0], ~nChipEnable};
      rdPipe <= {rdPipe[0], ~nOutputEnable};
      wrPipe <= {wrPipe[0], ~nWriteEnable};
      selPrev <= selPipe[1];
      // New cycle on a select edge or a new address under select
      bus.cycleStart <= selPipe[1] && (!selPrev || (addrPipe2 != addrPrev));
    end
  end

  always_ff @(posedge clk) begin
    addrPipe1 <= Address;
    addrPipe2 <= addrPipe1;
    addrPrev <= addrPipe2;
    dataPipe1 <= Data;
    dataPipe2 <= dataPipe1;
    // Address and data freeze once a strobe has been seen
    if (!rdPipe[1] && !wrPipe[1]) begin
      bus.address <= addrPipe2;
      bus.writeData <= dataPipe2;
    end
  end

  assign bus.selected = selPipe[1];
  assign bus.readStrobe = rdPipe[1];
  assign bus.writeStrobe = wrPipe[1];

  // Raw pins gate the driver so it lets go as soon as the host does
  assign driveData = !nChipEnable && !nOutputEnable && nWriteEnable && bus.readValid;
  assign Data = driveData ? bus.readData : {DataWidth{1'bz}};

endmodule

`default_nettype wire

/* verilog/mstCommandPort.sv */
`timescale 1ns/100ps
`default_nettype none

module mstCommandPort (
  input logic clk,
  input logic rst_n,
  input logic bus2ip_mst_cmdack,
  input logic bus2ip_mst_cmplt,
  input logic bus2ip_mst_error,
  input logic bus2ip_mst_cmd_timeout,
  input logic [mstBusPkg::MstDataWidth-1:0] bus2ip_mstrd_d,
  input logic bus2ip_mstrd_src_rdy_n,
  input logic bus2ip_mstwr_dst_rdy_n,
  output logic ip2bus_mstrd_req,
  output logic ip2bus_mstwr_req,
  output logic [mstBusPkg::MstAddrWidth-1:0] ip2bus_mst_addr,
  output logic [mstBusPkg::BeWidth-1:0] ip2bus_mst_be,
  output logic [mstBusPkg::MstDataWidth-1:0] ip2bus_mstwr_d,
  mstCmdIf.port cmd
);
  import mstBusPkg::*;

  logic rdActive;
  logic wrWaitRdy;
  logic wrActive;
  logic acked;
  logic [MstAddrWidth-1:0] addrReg;
  logic [ByteWidth-1:0] byteReg;
  logic [LaneBits-1:0] lane;
  mstWord_t rdView;
  mstWord_t wrView;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdActive <= 1'b0;
      wrWaitRdy <= 1'b0;
      wrActive <= 1'b0;
      acked <= 1'b0;
      cmd.done <= 1'b0;
      cmd.error <= 1'b0;
    end else begin
      cmd.done <= 1'b0;
      if (cmd.rdReq) begin
        rdActive <= 1'b1;
        acked <= 1'b0;
      end
      if (cmd.wrReq) begin
        // Write request waits for the destination to be ready
        wrActive <= !bus2ip_mstwr_dst_rdy_n;
        wrWaitRdy <= bus2ip_mstwr_dst_rdy_n;
        acked <= 1'b0;
      end
      if (wrWaitRdy && !bus2ip_mstwr_dst_rdy_n) begin
        wrWaitRdy <= 1'b0;
        wrActive <= 1'b1;
      end
      if ((rdActive || wrActive) && bus2ip_mst_cmdack) begin
        acked <= 1'b1;
      end
      // Completion only counts once the command has been acknowledged
      if ((rdActive || wrActive) && bus2ip_mst_cmplt && (acked || bus2ip_mst_cmdack)) begin
        rdActive <= 1'b0;
        wrActive <= 1'b0;
        acked <= 1'b0;
        cmd.done <= 1'b1;
        cmd.error <= bus2ip_mst_error || bus2ip_mst_cmd_timeout;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.rdReq || cmd.wrReq) begin
      addrReg <= cmd.addr;
      byteReg <= cmd.wrByte;
    end
    if (rdActive && !bus2ip_mstrd_src_rdy_n) begin
      cmd.rdByte <= rdView.bytes[lane];
    end
  end

  assign lane = addrReg[LaneBits-1:0];
  assign rdView.word = bus2ip_mstrd_d;

  // Only the addressed lane carries the write byte
  always_comb begin
    wrView.word = '0;
    wrView.bytes[lane] = byteReg;
  end

  assign ip2bus_mstrd_req = rdActive;
  assign ip2bus_mstwr_req = wrActive;
  assign ip2bus_mst_addr = addrReg;
  assign ip2bus_mst_be = BeWidth'(1) << lane;
  assign ip2bus_mstwr_d = wrView.word;

endmodule

`default_nettype wire

/* verilog/hostIntrChannel.sv */
`timescale 1ns/100ps
`default_nettype none

module hostIntrChannel (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic intrEnable,
  input logic intrStatus,
  output logic intr,
  output logic done
);

  logic waitClear;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      intr <= 1'b0;
      waitClear <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // Disabled channel passes straight through
        intr <= intrEnable;
        done <= !intrEnable;
      end else if (intr && intrStatus) begin
        // Host has registered the request
        intr <= 1'b0;
        waitClear <= 1'b1;
      end else if (waitClear && !intrStatus) begin
        waitClear <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bridgeSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module bridgeSequencer (
  input logic clk,
  input logic rst_n,
  input logic [mstBusPkg::MstDataWidth-1:0] ControlReg,
  input logic [ttlBusPkg::AddrWidth-1:0] BusAddressWriteReg,
  input logic [ttlBusPkg::DataWidth-1:0] BusDataWriteReg,
  input logic [mstBusPkg::MstAddrWidth-1:0] MappedAddress,
  input logic AddrReqIntrEnable,
  input logic DataReadReqIntrEnable,
  input logic DataWriteReqIntrEnable,
  input logic AddrReqIntrStatus,
  input logic DataReadReqIntrStatus,
  input logic DataWriteReqIntrStatus,
  output logic [mstBusPkg::MstDataWidth-1:0] StatusReg,
  output logic [ttlBusPkg::CtrlWidth-1:0] BusControlReadReg,
  output logic [ttlBusPkg::AddrWidth-1:0] BusAddressReadReg,
  output logic [ttlBusPkg::DataWidth-1:0] BusDataReadReg,
  output logic AddrReqIntr,
  output logic DataReadReqIntr,
  output logic DataWriteReqIntr,
  ttlCycleIf.seq bus,
  mstCmdIf.seq cmd
);
  import ttlBusPkg::*;
  import mstBusPkg::*;

  logic [SeqStateWidth-1:0] state;
  logic [CtrlWidth-1:0] busControl;
  logic [AddrWidth-1:0] busAddress;
  logic [DataWidth-1:0] busData;
  logic enable;
  logic enableMirror;
  logic mstError;
  logic busy;
  logic startCycle;
  logic addrStart, readStart, writeStart;
  logic addrDone, readDone, writeDone;

  assign enable = ControlReg[0];
  assign startCycle = enable && bus.cycleStart &&
                      (state == SeqIdle || state == SeqWaitStrobe || state == SeqHold);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SeqIdle;
      busControl <= '0;
      enableMirror <= 1'b0;
      mstError <= 1'b0;
      busy <= 1'b0;
      addrStart <= 1'b0;
      readStart <= 1'b0;
      writeStart <= 1'b0;
      bus.readValid <= 1'b0;
      cmd.rdReq <= 1'b0;
      cmd.wrReq <= 1'b0;
    end else begin
      addrStart <= 1'b0;
      readStart <= 1'b0;
      writeStart <= 1'b0;
      cmd.rdReq <= 1'b0;
      cmd.wrReq <= 1'b0;
      enableMirror <= enable;
      busControl[CtrlSelBit] <= enable && bus.selected;
      if (cmd.done && cmd.error) begin
        mstError <= 1'b1;
      end

      if (startCycle) begin
        // Also restarts a cycle whose address moved before a strobe
        busAddress <= bus.address;
        busControl[CtrlReadBit] <= 1'b0;
        busControl[CtrlWriteBit] <= 1'b0;
        bus.readValid <= 1'b0;
        busy <= 1'b1;
        addrStart <= 1'b1;
        state <= SeqAddrIntr;
      end else begin
        case (state)
          SeqAddrIntr: if (addrDone) begin
            if (AddrReqIntrEnable) begin
              busAddress <= BusAddressWriteReg;
            end
            state <= SeqWaitStrobe;
          end
          SeqWaitStrobe: if (!bus.selected) begin
            busy <= 1'b0;
            state <= SeqIdle;
          end else if (bus.readStrobe) begin
            cmd.addr <= MappedAddress + MstAddrWidth'(busAddress);
            cmd.rdReq <= 1'b1;
            busControl[CtrlReadBit] <= 1'b1;
            state <= SeqMstRead;
          end else if (bus.writeStrobe) begin
            cmd.addr <= MappedAddress + MstAddrWidth'(busAddress);
            busData <= bus.writeData;
            busControl[CtrlWriteBit] <= 1'b1;
            writeStart <= 1'b1;
            state <= SeqWriteIntr;
          end
          SeqMstRead: if (cmd.done) begin
            busData <= cmd.rdByte;
            readStart <= 1'b1;
            state <= SeqReadIntr;
          end
          SeqReadIntr: if (readDone) begin
            // Host may substitute the byte returned on the bus
            if (DataReadReqIntrEnable) begin
              busData <= BusDataWriteReg;
              bus.readData <= BusDataWriteReg;
            end else begin
              bus.readData <= busData;
            end
            bus.readValid <= 1'b1;
            state <= SeqHold;
          end
          SeqWriteIntr: if (writeDone) begin
            if (DataWriteReqIntrEnable) begin
              busData <= BusDataWriteReg;
            end
            cmd.wrReq <= 1'b1;
            state <= SeqMstWrite;
          end
          SeqMstWrite: if (cmd.done) begin
            state <= SeqHold;
          end
          SeqHold: if (!bus.readStrobe && !bus.writeStrobe) begin
            bus.readValid <= 1'b0;
            busy <= 1'b0;
            state <= SeqIdle;
          end
          default: state <= SeqIdle;
        endcase
      end
    end
  end

  assign cmd.wrByte = busData;

  hostIntrChannel addrIntr (
    .clk(clk), .rst_n(rst_n), .start(addrStart), .intrEnable(AddrReqIntrEnable),
    .intrStatus(AddrReqIntrStatus), .intr(AddrReqIntr), .done(addrDone)
  );

  hostIntrChannel readIntr (
    .clk(clk), .rst_n(rst_n), .start(readStart), .intrEnable(DataReadReqIntrEnable),
    .intrStatus(DataReadReqIntrStatus), .intr(DataReadReqIntr), .done(readDone)
  );

  hostIntrChannel writeIntr (
    .clk(clk), .rst_n(rst_n), .start(writeStart), .intrEnable(DataWriteReqIntrEnable),
    .intrStatus(DataWriteReqIntrStatus), .intr(DataWriteReqIntr), .done(writeDone)
  );

  always_comb begin
    StatusReg = '0;
    StatusReg[StatEnableBit] = enableMirror;
    StatusReg[StatErrorBit] = mstError;
    StatusReg[StatBusyBit] = busy;
  end

  assign BusControlReadReg = busControl;
  assign BusAddressReadReg = busAddress;
  assign BusDataReadReg = busData;

endmodule

`default_nettype wire

/* verilog/ttlMemoryBridge.sv */
`timescale 1ns/100ps
`default_nettype none

module ttlMemoryBridge (
  input logic clk,
  input logic rst_n,
  input logic nChipEnable,
  input logic nOutputEnable,
  input logic nWriteEnable,
  input logic [ttlBusPkg::AddrWidth-1:0] Address,
  inout wire [ttlBusPkg::DataWidth-1:0] Data,
  input logic [mstBusPkg::MstAddrWidth-1:0] MappedAddress,
  input logic [mstBusPkg::MstDataWidth-1:0] ControlReg,
  output logic [mstBusPkg::MstDataWidth-1:0] StatusReg,
  output logic [ttlBusPkg::CtrlWidth-1:0] BusControlReadReg,
  output logic [ttlBusPkg::AddrWidth-1:0] BusAddressReadReg,
  input logic [ttlBusPkg::AddrWidth-1:0] BusAddressWriteReg,
  output logic [ttlBusPkg::DataWidth-1:0] BusDataReadReg,
  input logic [ttlBusPkg::DataWidth-1:0] BusDataWriteReg,
  output logic AddrReqIntr,
  input logic AddrReqIntrStatus,
  input logic AddrReqIntrEnable,
  output logic DataReadReqIntr,
  input logic DataReadReqIntrStatus,
  input logic DataReadReqIntrEnable,
  output logic DataWriteReqIntr,
  input logic DataWriteReqIntrStatus,
  input logic DataWriteReqIntrEnable,
  output logic ip2bus_mstrd_req,
  output logic ip2bus_mstwr_req,
  output logic [mstBusPkg::MstAddrWidth-1:0] ip2bus_mst_addr,
  output logic [mstBusPkg::BeWidth-1:0] ip2bus_mst_be,
  output logic ip2bus_mst_reset,
  input logic bus2ip_mst_cmdack,
  input logic bus2ip_mst_cmplt,
  input logic bus2ip_mst_error,
  input logic bus2ip_mst_cmd_timeout,
  input logic [mstBusPkg::MstDataWidth-1:0] bus2ip_mstrd_d,
  input logic bus2ip_mstrd_src_rdy_n,
  output logic [mstBusPkg::MstDataWidth-1:0] ip2bus_mstwr_d,
  input logic bus2ip_mstwr_dst_rdy_n
);

  ttlCycleIf ttlBus ();
  mstCmdIf mstCmd ();

  ttlBusFrontEnd frontEnd (
    .clk(clk), .rst_n(rst_n), .nChipEnable(nChipEnable), .nOutputEnable(nOutputEnable),
    .nWriteEnable(nWriteEnable), .Address(Address), .Data(Data), .bus(ttlBus.front)
  );

  bridgeSequencer sequencer (
    .clk(clk), .rst_n(rst_n), .ControlReg(ControlReg),
    .BusAddressWriteReg(BusAddressWriteReg), .BusDataWriteReg(BusDataWriteReg),
    .MappedAddress(MappedAddress), .AddrReqIntrEnable(AddrReqIntrEnable),
    .DataReadReqIntrEnable(DataReadReqIntrEnable),
    .DataWriteReqIntrEnable(DataWriteReqIntrEnable), .AddrReqIntrStatus(AddrReqIntrStatus),
    .DataReadReqIntrStatus(DataReadReqIntrStatus),
    .DataWriteReqIntrStatus(DataWriteReqIntrStatus), .StatusReg(StatusReg),
    .BusControlReadReg(BusControlReadReg), .BusAddressReadReg(BusAddressReadReg),
    .BusDataReadReg(BusDataReadReg), .AddrReqIntr(AddrReqIntr),
    .DataReadReqIntr(DataReadReqIntr), .DataWriteReqIntr(DataWriteReqIntr),
    .bus(ttlBus.seq), .cmd(mstCmd.seq)
  );

  mstCommandPort cmdPort (
    .clk(clk), .rst_n(rst_n), .bus2ip_mst_cmdack(bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt(bus2ip_mst_cmplt), .bus2ip_mst_error(bus2ip_mst_error),
    .bus2ip_mst_cmd_timeout(bus2ip_mst_cmd_timeout), .bus2ip_mstrd_d(bus2ip_mstrd_d),
    .bus2ip_mstrd_src_rdy_n(bus2ip_mstrd_src_rdy_n),
    .bus2ip_mstwr_dst_rdy_n(bus2ip_mstwr_dst_rdy_n), .ip2bus_mstrd_req(ip2bus_mstrd_req),
    .ip2bus_mstwr_req(ip2bus_mstwr_req), .ip2bus_mst_addr(ip2bus_mst_addr),
    .ip2bus_mst_be(ip2bus_mst_be), .ip2bus_mstwr_d(ip2bus_mstwr_d), .cmd(mstCmd.port)
  );

  // Master side held in reset with the bridge
  assign ip2bus_mst_reset = ~rst_n;

endmodule

`default_nettype wire

/* sim/tbClockGen.sv */
`timescale 1ns/100ps
`default_nettype none

// Free-running 4 ns clock for the testbench
module tbClockGen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

`default_nettype wire

/* sim/ttlMemoryBridgeTb.sv */
`timescale 1ns/100ps
`default_nettype none

module ttlMemoryBridgeTb;

  localparam int BusCycles = 200;
  localparam int CycleLimit = BusCycles * 400;

  logic clk;
  logic rst_n;
  logic nChipEnable, nOutputEnable, nWriteEnable;
  logic [15:0] Address;
  tri1 [7:0] Data;
  logic [31:0] MappedAddress, ControlReg;
  logic [15:0] BusAddressWriteReg;
  logic [7:0] BusDataWriteReg;
  logic [2:0] intrEn, intrStat;
  wire [31:0] StatusReg;
  wire [2:0] BusControlReadReg;
  wire [15:0] BusAddressReadReg;
  wire [7:0] BusDataReadReg;
  wire AddrReqIntr, DataReadReqIntr, DataWriteReqIntr;
  wire [2:0] intrLine;
  wire ip2bus_mstrd_req, ip2bus_mstwr_req, ip2bus_mst_reset;
  wire [31:0] ip2bus_mst_addr, ip2bus_mstwr_d;
  wire [3:0] ip2bus_mst_be;
  logic bus2ip_mst_cmdack, bus2ip_mst_cmplt, bus2ip_mst_error, bus2ip_mst_cmd_timeout;
  logic [31:0] bus2ip_mstrd_d;
  logic bus2ip_mstrd_src_rdy_n, bus2ip_mstwr_dst_rdy_n;

  // TTL host side of the shared data bus
  logic tbDriveEn;
  logic [7:0] tbData;
  assign Data = tbDriveEn ? tbData : 8'bz;
  assign intrLine = {DataWriteReqIntr, DataReadReqIntr, AddrReqIntr};

  // Slave memory and the expected image
  logic [31:0] mem [256];
  logic [31:0] modelMem [256];
  logic [31:0] lastAddr;
  logic [3:0] lastBe;
  logic expErr;
  int doneCount, reqCount, cycleCount;
  int hostDone [3];
  logic [15:0] hostAddr;
  logic [7:0] hostData;

  tbClockGen clkGen (.clk(clk));

  ttlMemoryBridge dut_i (
    .clk(clk), .rst_n(rst_n), .nChipEnable(nChipEnable), .nOutputEnable(nOutputEnable),
    .nWriteEnable(nWriteEnable), .Address(Address), .Data(Data),
    .MappedAddress(MappedAddress), .ControlReg(ControlReg), .StatusReg(StatusReg),
    .BusControlReadReg(BusControlReadReg), .BusAddressReadReg(BusAddressReadReg),
    .BusAddressWriteReg(BusAddressWriteReg), .BusDataReadReg(BusDataReadReg),
    .BusDataWriteReg(BusDataWriteReg), .AddrReqIntr(AddrReqIntr),
    .AddrReqIntrStatus(intrStat[0]), .AddrReqIntrEnable(intrEn[0]),
    .DataReadReqIntr(DataReadReqIntr), .DataReadReqIntrStatus(intrStat[1]),
    .DataReadReqIntrEnable(intrEn[1]), .DataWriteReqIntr(DataWriteReqIntr),
    .DataWriteReqIntrStatus(intrStat[2]), .DataWriteReqIntrEnable(intrEn[2]),
    .ip2bus_mstrd_req(ip2bus_mstrd_req), .ip2bus_mstwr_req(ip2bus_mstwr_req),
    .ip2bus_mst_addr(ip2bus_mst_addr), .ip2bus_mst_be(ip2bus_mst_be),
    .ip2bus_mst_reset(ip2bus_mst_reset), .bus2ip_mst_cmdack(bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt(bus2ip_mst_cmplt), .bus2ip_mst_error(bus2ip_mst_error),
    .bus2ip_mst_cmd_timeout(bus2ip_mst_cmd_timeout), .bus2ip_mstrd_d(bus2ip_mstrd_d),
    .bus2ip_mstrd_src_rdy_n(bus2ip_mstrd_src_rdy_n), .ip2bus_mstwr_d(ip2bus_mstwr_d),
    .bus2ip_mstwr_dst_rdy_n(bus2ip_mstwr_dst_rdy_n)
  );

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Inputs change half a nanosecond after the rising edge
  task automatic tick();
    @(posedge clk);
    #0.5;
  endtask

  // Every word index gives its own pattern
  function automatic logic [31:0] fillWord(input logic [7:0] idx);
    return {idx ^ 8'ha5, idx + 8'h3c, ~idx, idx};
  endfunction

  task automatic answerHost(input int ch);
    logic [31:0] r;
    forever begin
      tick();
      if (intrLine[ch]) begin
        repeat ($urandom_range(0, 5)) tick();
        r = $urandom;
        if (ch == 0) begin
          hostAddr = r[15:0];
          BusAddressWriteReg = r[15:0];
        end else begin
          hostData = r[7:0];
          BusDataWriteReg = r[7:0];
        end
        intrStat[ch] = 1'b1;
        tick();
        // Interrupt must drop once the status level is seen
        checkValue("intr line", 32'(intrLine[ch]), 32'h0);
        repeat ($urandom_range(0, 5)) tick();
        intrStat[ch] = 1'b0;
        hostDone[ch]++;
      end
    end
  endtask

  task automatic serveMaster();
    logic [31:0] r;
    logic isWr;
    forever begin
      tick();
      if (ip2bus_mstrd_req || ip2bus_mstwr_req) begin
        isWr = ip2bus_mstwr_req;
        reqCount++;
        lastAddr = ip2bus_mst_addr;
        lastBe = ip2bus_mst_be;
        repeat ($urandom_range(0, 3)) tick();
        bus2ip_mst_cmdack = 1'b1;
        tick();
        bus2ip_mst_cmdack = 1'b0;
        repeat ($urandom_range(0, 3)) tick();
        if (isWr) begin
          for (int l = 0; l < 4; l++) begin
            if (ip2bus_mst_be[l]) begin
              mem[ip2bus_mst_addr[9:2]][8*l +: 8] = ip2bus_mstwr_d[8*l +: 8];
            end
          end
        end else begin
          bus2ip_mstrd_d = mem[ip2bus_mst_addr[9:2]];
          bus2ip_mstrd_src_rdy_n = 1'b0;
          tick();
          bus2ip_mstrd_src_rdy_n = 1'b1;
        end
        r = $urandom_range(0, 15);
        bus2ip_mst_error = (r == 0);
        bus2ip_mst_cmd_timeout = (r == 1);
        if (r < 2) expErr = 1'b1;
        bus2ip_mst_cmplt = 1'b1;
        tick();
        bus2ip_mst_cmplt = 1'b0;
        bus2ip_mst_error = 1'b0;
        bus2ip_mst_cmd_timeout = 1'b0;
        doneCount++;
      end
    end
  endtask

  task automatic finishCycle();
    while (StatusReg[2]) tick();
    repeat (5) tick();
    checkValue("StatusReg[2]", 32'(StatusReg[2]), 32'h0);
    checkValue("BusControlReadReg[0]", 32'(BusControlReadReg[0]), 32'h0);
    checkValue("StatusReg[1]", 32'(StatusReg[1]), 32'(expErr));
    checkValue("StatusReg[0]", 32'(StatusReg[0]), 32'(ControlReg[0]));
  endtask

  task automatic readCycle(input logic [15:0] addr);
    int doneBefore;
    int hostBefore;
    int lane;
    logic [15:0] effAddr;
    logic [31:0] mstAddr;
    logic [7:0] expByte;
    doneBefore = doneCount;
    hostBefore = hostDone[1];
    Address = addr;
    nChipEnable = 1'b0;
    repeat (6) tick();
    nOutputEnable = 1'b0;
    while (doneCount == doneBefore) tick();
    if (intrEn[1]) begin
      while (hostDone[1] == hostBefore) tick();
    end
    repeat (5) tick();
    effAddr = intrEn[0] ? hostAddr : addr;
    mstAddr = MappedAddress + {16'h0, effAddr};
    lane = int'(mstAddr[1:0]);
    expByte = intrEn[1] ? hostData : modelMem[mstAddr[9:2]][8*lane +: 8];
    checkValue("ip2bus_mst_addr", lastAddr, mstAddr);
    checkValue("ip2bus_mst_be", 32'(lastBe), 32'(4'b0001 << lane));
    checkValue("Data", 32'(Data), 32'(expByte));
    checkValue("BusAddressReadReg", 32'(BusAddressReadReg), 32'(effAddr));
    checkValue("BusDataReadReg", 32'(BusDataReadReg), 32'(expByte));
    // Select and read bits set while the read is held
    checkValue("BusControlReadReg", 32'(BusControlReadReg), 32'(3'b011));
    checkValue("StatusReg[2]", 32'(StatusReg[2]), 32'h1);
    nOutputEnable = 1'b1;
    #1;
    checkValue("Data", 32'(Data), 32'hff);
    nChipEnable = 1'b1;
    finishCycle();
  endtask

  task automatic writeCycle(input logic [15:0] addr, input logic [7:0] wd);
    int doneBefore;
    int lane;
    logic [15:0] effAddr;
    logic [31:0] mstAddr;
    logic [7:0] expByte;
    doneBefore = doneCount;
    Address = addr;
    tbData = wd;
    tbDriveEn = 1'b1;
    nChipEnable = 1'b0;
    repeat (6) tick();
    nWriteEnable = 1'b0;
    while (doneCount == doneBefore) tick();
    effAddr = intrEn[0] ? hostAddr : addr;
    mstAddr = MappedAddress + {16'h0, effAddr};
    lane = int'(mstAddr[1:0]);
    expByte = intrEn[2] ? hostData : wd;
    modelMem[mstAddr[9:2]][8*lane +: 8] = expByte;
    checkValue("ip2bus_mst_addr", lastAddr, mstAddr);
    checkValue("ip2bus_mst_be", 32'(lastBe), 32'(4'b0001 << lane));
    checkValue("memory word", mem[mstAddr[9:2]], modelMem[mstAddr[9:2]]);
    checkValue("BusAddressReadReg", 32'(BusAddressReadReg), 32'(effAddr));
    checkValue("BusDataReadReg", 32'(BusDataReadReg), 32'(expByte));
    // Select and write bits set during the write
    checkValue("BusControlReadReg", 32'(BusControlReadReg), 32'(3'b101));
    checkValue("StatusReg[2]", 32'(StatusReg[2]), 32'h1);
    nWriteEnable = 1'b1;
    nChipEnable = 1'b1;
    tbDriveEn = 1'b0;
    finishCycle();
  endtask

  // With the bridge off nothing may reach the master side
  task automatic gatedCycle(input logic isWrite);
    int reqBefore;
    logic [31:0] r;
    reqBefore = reqCount;
    r = $urandom;
    Address = r[15:0];
    tbData = r[23:16];
    tbDriveEn = isWrite;
    nChipEnable = 1'b0;
    repeat (4) tick();
    nOutputEnable = isWrite;
    nWriteEnable = !isWrite;
    repeat (20) tick();
    if (!isWrite) checkValue("Data", 32'(Data), 32'hff);
    nOutputEnable = 1'b1;
    nWriteEnable = 1'b1;
    nChipEnable = 1'b1;
    tbDriveEn = 1'b0;
    repeat (10) tick();
    checkValue("master request count", 32'(reqCount), 32'(reqBefore));
    checkValue("StatusReg[0]", 32'(StatusReg[0]), 32'h0);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("** FAIL **");
      $fatal(1, "Timeout: the bridge stopped responding before the tests ended");
    end
  end

  initial begin
    logic [31:0] r;
    void'($urandom(32'hcfd5bdbd));
    rst_n = 1'b0;
    {nChipEnable, nOutputEnable, nWriteEnable} = 3'b111;
    Address = '0;
    tbDriveEn = 1'b0;
    tbData = '0;
    MappedAddress = '0;
    ControlReg = '0;
    BusAddressWriteReg = '0;
    BusDataWriteReg = '0;
    intrEn = '0;
    intrStat = '0;
    bus2ip_mst_cmdack = 1'b0;
    bus2ip_mst_cmplt = 1'b0;
    bus2ip_mst_error = 1'b0;
    bus2ip_mst_cmd_timeout = 1'b0;
    bus2ip_mstrd_d = '0;
    bus2ip_mstrd_src_rdy_n = 1'b1;
    bus2ip_mstwr_dst_rdy_n = 1'b1;
    expErr = 1'b0;
    doneCount = 0;
    reqCount = 0;
    hostDone = '{0, 0, 0};
    hostAddr = '0;
    hostData = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fillWord(8'(i));
      modelMem[i] = fillWord(8'(i));
    end
    repeat (8) tick();
    checkValue("ip2bus_mst_reset", 32'(ip2bus_mst_reset), 32'h1);
    rst_n = 1'b1;
    tick();
    checkValue("ip2bus_mst_reset", 32'(ip2bus_mst_reset), 32'h0);
    checkValue("StatusReg", StatusReg, 32'h0);
    checkValue("master requests", 32'({ip2bus_mstrd_req, ip2bus_mstwr_req}), 32'h0);
    checkValue("interrupts", 32'(intrLine), 32'h0);
    checkValue("Data", 32'(Data), 32'hff);

    fork
      answerHost(0);
      answerHost(1);
      answerHost(2);
      serveMaster();
      forever begin
        tick();
        bus2ip_mstwr_dst_rdy_n = 1'($urandom_range(0, 1));
      end
    join_none

    r = $urandom;
    MappedAddress = r;
    ControlReg = 32'h1;
    repeat (4) tick();
    // Plain cycles first and random interrupt enables in the second half
    for (int n = 0; n < 80; n++) begin
      if (n >= 40) intrEn = 3'($urandom_range(0, 7));
      r = $urandom;
      if (r[24]) writeCycle(r[15:0], r[23:16]);
      else readCycle(r[15:0]);
    end
    intrEn = '0;
    ControlReg = 32'h0;
    repeat (4) tick();
    for (int n = 0; n < 6; n++) begin
      gatedCycle(1'(n % 2));
    end
    checkValue("StatusReg[1]", 32'(StatusReg[1]), 32'(expErr));
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/ttlBusPkg.sv
verilog/mstBusPkg.sv
verilog/bridgeIfs.sv
verilog/ttlBusFrontEnd.sv
verilog/mstCommandPort.sv
verilog/hostIntrChannel.sv
verilog/bridgeSequencer.sv
verilog/ttlMemoryBridge.sv
sim/tbClockGen.sv
sim/ttlMemoryBridgeTb.sv

/* Makefile */
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module ttlMemoryBridgeTb \
		--Mdir $(OBJ_DIR) -o ttlMemoryBridgeTb
	./$(OBJ_DIR)/ttlMemoryBridgeTb

clean:
	rm -rf $(OBJ_DIR)
